// File: verilog/pipe_pkg.sv
package pipe_pkg;

    ////////////////////
    // Data and memory geometry

    localparam int LINE_WIDTH = 32;
    localparam int ADDR_WIDTH = 8;
    localparam int BRAM_DEPTH = 1 << ADDR_WIDTH;

    ////////////////////
    // Configuration word layout

    localparam int CFG_WIDTH = 32;

    // Shared by read and write config
    localparam int CFG_OFFSET_LSB = 0;
    localparam int CFG_OFFSET_MSB = 15;

    // Read config only
    localparam int CFG_LENGTH_LSB = 16;
    localparam int CFG_LENGTH_MSB = 31;

    ////////////////////
    // Line FIFO sizing

    localparam int FIFO_DEPTH = 16;

    // Re register, BRAM read and add stage can hold three lines, plus one spare
    localparam int FIFO_SLACK = 4;

endpackage

// File: verilog/bram_dp.sv
`timescale 1ns/1ps

module bram_dp import pipe_pkg::*;
(
    input  logic                  clk,

    input  logic                  we,
    input  logic [ADDR_WIDTH-1:0] waddr,
    input  logic [LINE_WIDTH-1:0] wdata,

    input  logic                  re,
    input  logic [ADDR_WIDTH-1:0] raddr,
    output logic                  rvalid,
    output logic [LINE_WIDTH-1:0] rdata
);

    logic [LINE_WIDTH-1:0] mem [BRAM_DEPTH];

    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read, old data on a same-address collision
    always_ff @(posedge clk)
    begin
        if (re)
        begin
            rdata <= mem[raddr];
        end
    end

    always_ff @(posedge clk)
    begin
        rvalid <= re;
    end

endmodule

// File: verilog/read_bram.sv
`timescale 1ns/1ps

module read_bram import pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  op_start,
    input  logic [CFG_WIDTH-1:0]  configreg,

    input  logic                  almostfull,
    output logic                  re,
    output logic [ADDR_WIDTH-1:0] raddr
);

    logic                                     busy;
    logic [CFG_OFFSET_MSB-CFG_OFFSET_LSB:0]   offset;
    logic [CFG_LENGTH_MSB-CFG_LENGTH_LSB:0]   length;
    logic [CFG_LENGTH_MSB-CFG_LENGTH_LSB:0]   count;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy <= 1'b0;
            re   <= 1'b0;
        end
        else
        begin
            re <= 1'b0;
            if (!busy)
            begin
                if (op_start)
                begin
                    offset <= configreg[CFG_OFFSET_MSB:CFG_OFFSET_LSB];
                    length <= configreg[CFG_LENGTH_MSB:CFG_LENGTH_LSB];
                    count  <= '0;
                    // Nothing to fetch for a zero length
                    busy   <= (configreg[CFG_LENGTH_MSB:CFG_LENGTH_LSB] != '0);
                end
            end
            else if (count < length && !almostfull)
            begin
                re    <= 1'b1;
                raddr <= offset[ADDR_WIDTH-1:0] + count[ADDR_WIDTH-1:0];
                count <= count + 1'b1;
                if (count == length - 1'b1)
                begin
                    busy <= 1'b0;
                end
            end
        end
    end

endmodule

// File: verilog/add_stage.sv
`timescale 1ns/1ps

module add_stage import pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  load,
    input  logic [LINE_WIDTH-1:0] add_value,

    input  logic                  in_valid,
    input  logic [LINE_WIDTH-1:0] in_data,

    output logic                  out_valid,
    output logic [LINE_WIDTH-1:0] out_data
);

    logic [LINE_WIDTH-1:0] add_q;
    logic [LINE_WIDTH:0]   sum;

    // Extra bit catches the carry out
    assign sum = {1'b0, in_data} + {1'b0, add_q};

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            add_q <= add_value;
        end
    end

    always_ff @(posedge clk)
    begin
        if (in_valid)
        begin
            // Clamp to all ones on overflow
            out_data <= sum[LINE_WIDTH] ? '1 : sum[LINE_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            out_valid <= 1'b0;
        end
        else
        begin
            out_valid <= in_valid;
        end
    end

endmodule

// File: verilog/line_fifo.sv
`timescale 1ns/1ps

module line_fifo import pipe_pkg::*;
#(
    parameter int DEPTH = FIFO_DEPTH
)
(
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  push,
    input  logic [LINE_WIDTH-1:0] push_data,

    input  logic                  pop,
    output logic [LINE_WIDTH-1:0] pop_data,

    output logic                  empty,
    output logic                  almostfull
);

    logic [LINE_WIDTH-1:0]      mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH):0]     count;
    logic                       full;

    assign full       = (count == ($clog2(DEPTH)+1)'(DEPTH));
    assign empty      = (count == '0);
    assign almostfull = (count >= ($clog2(DEPTH)+1)'(DEPTH - FIFO_SLACK));

    // Head line shown without a register
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    ////////////////////
    // Checks

    // Upstream must have stopped on almostfull early enough
    assert property (@(posedge clk) disable iff (reset) full |-> !push);

    // Write engine must only drain a non-empty FIFO
    assert property (@(posedge clk) disable iff (reset) empty |-> !pop);

endmodule

// File: verilog/write_bram.sv
`timescale 1ns/1ps

module write_bram import pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  op_start,
    input  logic [CFG_WIDTH-1:0]  configreg,
    input  logic [15:0]           length,

    input  logic                  hold,
    input  logic                  empty,
    output logic                  pop,

    output logic                  we,
    output logic [ADDR_WIDTH-1:0] waddr,
    output logic                  done
);

    logic                                   busy;
    logic [CFG_OFFSET_MSB-CFG_OFFSET_LSB:0] offset;
    logic [15:0]                            length_q;
    logic [15:0]                            count;

    // Pop and write share a cycle since the FIFO head is combinational
    assign pop   = busy && !empty && !hold;
    assign we    = pop;
    assign waddr = offset[ADDR_WIDTH-1:0] + count[ADDR_WIDTH-1:0];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy <= 1'b0;
            done <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (!busy)
            begin
                if (op_start)
                begin
                    offset   <= configreg[CFG_OFFSET_MSB:CFG_OFFSET_LSB];
                    length_q <= length;
                    count    <= '0;
                    if (length == '0)
                    begin
                        done <= 1'b1;
                    end
                    else
                    begin
                        busy <= 1'b1;
                    end
                end
            end
            else if (pop)
            begin
                count <= count + 1'b1;
                // Last line of the range
                if (count == length_q - 1'b1)
                begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

endmodule

// File: verilog/pipe_top.sv
`timescale 1ns/1ps

module pipe_top import pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  load_we,
    input  logic [ADDR_WIDTH-1:0] load_addr,
    input  logic [LINE_WIDTH-1:0] load_data,

    input  logic                  op_start,
    input  logic [CFG_WIDTH-1:0]  read_config,
    input  logic [CFG_WIDTH-1:0]  write_config,
    input  logic [LINE_WIDTH-1:0] add_value,
    input  logic                  hold,
    output logic                  done,

    input  logic [ADDR_WIDTH-1:0] dump_addr,
    output logic [LINE_WIDTH-1:0] dump_data
);

    logic                  src_re;
    logic [ADDR_WIDTH-1:0] src_raddr;
    logic                  src_rvalid;
    logic [LINE_WIDTH-1:0] src_rdata;
    logic                  add_valid;
    logic [LINE_WIDTH-1:0] add_data;
    logic                  fifo_pop;
    logic [LINE_WIDTH-1:0] fifo_data;
    logic                  fifo_empty;
    logic                  fifo_almostfull;
    logic                  dst_we;
    logic [ADDR_WIDTH-1:0] dst_waddr;

    ////////////////////
    // Source side

    bram_dp u_src
    (
        .clk    (clk),
        .we     (load_we),
        .waddr  (load_addr),
        .wdata  (load_data),
        .re     (src_re),
        .raddr  (src_raddr),
        .rvalid (src_rvalid),
        .rdata  (src_rdata)
    );

    read_bram u_read_bram
    (
        .clk        (clk),
        .reset      (reset),
        .op_start   (op_start),
        .configreg  (read_config),
        .almostfull (fifo_almostfull),
        .re         (src_re),
        .raddr      (src_raddr)
    );

    add_stage u_add_stage
    (
        .clk       (clk),
        .reset     (reset),
        .load      (op_start),
        .add_value (add_value),
        .in_valid  (src_rvalid),
        .in_data   (src_rdata),
        .out_valid (add_valid),
        .out_data  (add_data)
    );

    line_fifo u_line_fifo
    (
        .clk        (clk),
        .reset      (reset),
        .push       (add_valid),
        .push_data  (add_data),
        .pop        (fifo_pop),
        .pop_data   (fifo_data),
        .empty      (fifo_empty),
        .almostfull (fifo_almostfull)
    );

    ////////////////////
    // Destination side

    write_bram u_write_bram
    (
        .clk       (clk),
        .reset     (reset),
        .op_start  (op_start),
        .configreg (write_config),
        .length    (read_config[CFG_LENGTH_MSB:CFG_LENGTH_LSB]),
        .hold      (hold),
        .empty     (fifo_empty),
        .pop       (fifo_pop),
        .we        (dst_we),
        .waddr     (dst_waddr),
        .done      (done)
    );

    // Dump port reads every cycle
    bram_dp u_dst
    (
        .clk    (clk),
        .we     (dst_we),
        .waddr  (dst_waddr),
        .wdata  (fifo_data),
        .re     (1'b1),
        .raddr  (dump_addr),
        .rvalid (),
        .rdata  (dump_data)
    );

endmodule

// File: verification/pipe_tb.sv
`timescale 1ns/1ps

module pipe_tb import pipe_pkg::*;
();

    ////////////////////
    // Test table

    localparam int NUM_TESTS     = 6;
    localparam int HOLD_NONE     = 0;
    localparam int HOLD_PERIODIC = 1;
    localparam int HOLD_BURST    = 2;
    localparam int DONE_TIMEOUT  = 2000;

    // Rows: plain copy, saturating add, long hold, zero length, then two back to back
    localparam logic [15:0] RD_OFF [NUM_TESTS] = '{16'd0, 16'd30, 16'd100, 16'd10, 16'd200, 16'd250};
    localparam logic [15:0] LEN    [NUM_TESTS] = '{16'd20, 16'd25, 16'd60, 16'd0, 16'd16, 16'd12};
    localparam logic [15:0] WR_OFF [NUM_TESTS] = '{16'd0, 16'd40, 16'd100, 16'd0, 16'd180, 16'd10};
    localparam logic [LINE_WIDTH-1:0] ADD [NUM_TESTS] =
        '{32'h0000_0000, 32'h8000_0000, 32'h0000_0005, 32'h0000_0007, 32'h0000_0001,
          32'h0000_1000};
    localparam int HOLD_MODE [NUM_TESTS] =
        '{HOLD_NONE, HOLD_PERIODIC, HOLD_BURST, HOLD_NONE, HOLD_PERIODIC, HOLD_NONE};

    logic                  clk;
    logic                  reset;
    logic                  load_we;
    logic [ADDR_WIDTH-1:0] load_addr;
    logic [LINE_WIDTH-1:0] load_data;
    logic                  op_start;
    logic [CFG_WIDTH-1:0]  read_config;
    logic [CFG_WIDTH-1:0]  write_config;
    logic [LINE_WIDTH-1:0] add_value;
    logic                  hold;
    logic                  done;
    logic [ADDR_WIDTH-1:0] dump_addr;
    logic [LINE_WIDTH-1:0] dump_data;

    logic [LINE_WIDTH-1:0] src_model [BRAM_DEPTH];
    logic [LINE_WIDTH-1:0] dst_model [BRAM_DEPTH];
    bit                    dst_known [BRAM_DEPTH];
    integer                seed;
    int                    done_count;
    int                    checks;
    int                    errors;

    pipe_top i_pipe_top
    (
        .clk          (clk),
        .reset        (reset),
        .load_we      (load_we),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .op_start     (op_start),
        .read_config  (read_config),
        .write_config (write_config),
        .add_value    (add_value),
        .hold         (hold),
        .done         (done),
        .dump_addr    (dump_addr),
        .dump_data    (dump_data)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #10 clk = ~clk;
        end
    end

    always @(negedge clk)
    begin
        if (!reset && done === 1'b1)
        begin
            done_count <= done_count + 1;
        end
    end

    ////////////////////
    // Checks and model

    task automatic check_line(input string name, input logic [LINE_WIDTH-1:0] got,
                              input logic [LINE_WIDTH-1:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Fail t=%0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_done(input int got, input int exp);
        checks++;
        if (got != exp)
        begin
            errors++;
            $display("Fail t=%0t done pulses: got %0d, expected %0d", $time, got, exp);
        end
    endtask

    // Sum clamped to all ones when it would not fit
    function automatic logic [LINE_WIDTH-1:0] add_saturate(input logic [LINE_WIDTH-1:0] a,
                                                           input logic [LINE_WIDTH-1:0] b);
        if (a > ~b)
        begin
            return '1;
        end
        return a + b;
    endfunction

    function automatic logic hold_level(input int mode, input int cyc);
        case (mode)
            HOLD_PERIODIC: return (cyc % 3) == 1;
            HOLD_BURST:    return cyc < 80;
            default:       return 1'b0;
        endcase
    endfunction

    task automatic update_model(input int t);
        logic [ADDR_WIDTH-1:0] sa;
        logic [ADDR_WIDTH-1:0] da;
        for (int i = 0; i < int'(LEN[t]); i++)
        begin
            sa = ADDR_WIDTH'(int'(RD_OFF[t]) + i);
            da = ADDR_WIDTH'(int'(WR_OFF[t]) + i);
            dst_model[da] = add_saturate(src_model[sa], ADD[t]);
            dst_known[da] = 1'b1;
        end
    endtask

    ////////////////////
    // Stimulus

    task automatic load_source();
        logic [LINE_WIDTH-1:0] v;
        logic [ADDR_WIDTH-1:0] a;
        for (int i = 0; i < BRAM_DEPTH; i++)
        begin
            a = ADDR_WIDTH'(i);
            v = $random(seed);
            // Every tenth word just below all ones
            if (i % 10 == 0)
            begin
                v = '1 - (v & 32'h0000_00ff);
            end
            @(posedge clk);
            load_we   <= 1'b1;
            load_addr <= a;
            load_data <= v;
            src_model[a] = v;
        end
        @(posedge clk);
        load_we <= 1'b0;
    endtask

    task automatic start_op(input int t);
        @(posedge clk);
        read_config  <= {LEN[t], RD_OFF[t]};
        write_config <= {16'h0000, WR_OFF[t]};
        add_value    <= ADD[t];
        op_start     <= 1'b1;
        @(posedge clk);
        op_start <= 1'b0;
    endtask

    task automatic wait_done(input int mode, input int start_count, output bit timed_out);
        int cyc;
        cyc = 0;
        timed_out = 1'b0;
        while (done_count == start_count && !timed_out)
        begin
            @(posedge clk);
            hold <= hold_level(mode, cyc);
            cyc++;
            @(negedge clk);
            if (done_count == start_count && cyc >= DONE_TIMEOUT)
            begin
                timed_out = 1'b1;
            end
        end
        @(posedge clk);
        hold <= 1'b0;
    endtask

    // Whole destination, wherever the model holds a known value
    task automatic dump_and_check();
        logic [ADDR_WIDTH-1:0] a;
        for (int i = 0; i < BRAM_DEPTH; i++)
        begin
            a = ADDR_WIDTH'(i);
            @(posedge clk);
            dump_addr <= a;
            @(posedge clk);
            @(negedge clk);
            if (dst_known[a])
            begin
                check_line($sformatf("dump_data[%0d]", i), dump_data, dst_model[a]);
            end
        end
    endtask

    initial
    begin
        int  start_count;
        int  errors_before;
        int  tests_run;
        bit  timed_out;
        seed         = 32'h35a965b8;
        done_count   = 0;
        checks       = 0;
        errors       = 0;
        tests_run    = 0;
        timed_out    = 1'b0;
        reset        = 1'b1;
        load_we      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        op_start     = 1'b0;
        read_config  = '0;
        write_config = '0;
        add_value    = '0;
        hold         = 1'b0;
        dump_addr    = '0;

        repeat (2) @(posedge clk);
        reset <= 1'b0;

        load_source();

        // No done pulse before any operation
        repeat (10) @(posedge clk);
        @(negedge clk);
        errors_before = errors;
        check_done(done_count, 0);
        $display("Reset check: %s", (errors == errors_before) ? "ok" : "errors");

        for (int t = 0; t < NUM_TESTS && !timed_out; t++)
        begin
            errors_before = errors;
            start_count   = done_count;
            start_op(t);
            wait_done(HOLD_MODE[t], start_count, timed_out);
            if (timed_out)
            begin
                $display("Test %0d timed out waiting for done after %0d cycles", t,
                         DONE_TIMEOUT);
            end
            else
            begin
                repeat (4) @(posedge clk);
                @(negedge clk);
                check_done(done_count - start_count, 1);
                update_model(t);
                dump_and_check();
                tests_run++;
                $display("Test %0d (length %0d, hold mode %0d): %0d errors", t, LEN[t],
                         HOLD_MODE[t], errors - errors_before);
            end
        end

        $display("Tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0 && !timed_out)
        begin
            $display("sim passed");
        end
        else
        begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: flist.f
verilog/pipe_pkg.sv
verilog/bram_dp.sv
verilog/read_bram.sv
verilog/add_stage.sv
verilog/line_fifo.sv
verilog/write_bram.sv
verilog/pipe_top.sv
verification/pipe_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module pipe_tb -f flist.f -Mdir obj_dir
	./obj_dir/Vpipe_tb | tee $(LOG)
	@if grep -q "^sim passed$$" $(LOG); then \
		echo "Result: PASS"; \
	else \
		echo "Result: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
